// File: Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+verilog
verilog/mips_isa_pkg.sv
verilog/id_stage_pkg.sv
verilog/inst_decoder.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/load_use_hazard.sv
verilog/id_ex_register.sv
verilog/id_stage.sv
sim/id_stage_properties.sv
sim/id_stage_checker.sv
sim/id_stage_tb.sv

// File: sim/id_stage_checker.sv
`timescale 1ns/1ns

module id_stage_checker
    import id_stage_pkg::*;
#(
    parameter int NAME_W = 96
) (
    input  logic              clk_i,
    input  logic              row_valid_i,
    input  logic [NAME_W-1:0] name_i,
    input  rf_read_t          exp_rd1_i,
    input  rf_read_t          exp_rd2_i,
    input  logic              exp_stall_i,
    input  branch_t           exp_branch_i,
    input  id_ex_t            exp_bundle_i,
    input  rf_read_t          rd1_i,
    input  rf_read_t          rd2_i,
    input  logic              stall_i,
    input  branch_t           branch_i,
    input  id_ex_t            bundle_i,
    output int                tests_o,
    output int                errors_o
);

    logic              pending;
    logic              ok;
    logic [NAME_W-1:0] cap_name;
    rf_read_t          cap_exp_rd1;
    rf_read_t          cap_exp_rd2;
    logic              cap_exp_stall;
    branch_t           cap_exp_branch;
    id_ex_t            cap_exp_bundle;
    rf_read_t          cap_rd1;
    rf_read_t          cap_rd2;
    logic              cap_stall;
    branch_t           cap_branch;

    // a disabled read carries no meaningful address
    function automatic logic read_ok(rf_read_t want, rf_read_t got);
        if (want.en) begin
            return got === want;
        end
        return got.en === 1'b0;
    endfunction

    initial begin
        pending  = 1'b0;
        tests_o  = 0;
        errors_o = 0;
    end

    // combinational outputs are settled by mid cycle
    always @(negedge clk_i) begin
        if (row_valid_i) begin
            cap_name       = name_i;
            cap_exp_rd1    = exp_rd1_i;
            cap_exp_rd2    = exp_rd2_i;
            cap_exp_stall  = exp_stall_i;
            cap_exp_branch = exp_branch_i;
            cap_exp_bundle = exp_bundle_i;
            cap_rd1        = rd1_i;
            cap_rd2        = rd2_i;
            cap_stall      = stall_i;
            cap_branch     = branch_i;
            pending        = 1'b1;
        end
    end

    // bundle is read just after the edge that loads it
    always @(posedge clk_i) begin
        #1;
        if (pending) begin
            ok = 1'b1;
            if (!read_ok(cap_exp_rd1, cap_rd1) || !read_ok(cap_exp_rd2, cap_rd2)) begin
                $display("Mismatch %0s: reads expected %h %h actual %h %h",
                         cap_name, cap_exp_rd1, cap_exp_rd2, cap_rd1, cap_rd2);
                ok = 1'b0;
            end
            if (cap_stall !== cap_exp_stall) begin
                $display("Mismatch %0s: stall expected %0b actual %0b",
                         cap_name, cap_exp_stall, cap_stall);
                ok = 1'b0;
            end
            // branch outputs only count without a stall
            if (!cap_exp_stall && cap_branch !== cap_exp_branch) begin
                $display("Mismatch %0s: branch expected %h actual %h",
                         cap_name, cap_exp_branch, cap_branch);
                ok = 1'b0;
            end
            if (bundle_i !== cap_exp_bundle) begin
                $display("Mismatch %0s: bundle expected %h actual %h",
                         cap_name, cap_exp_bundle, bundle_i);
                ok = 1'b0;
            end
            if (ok) begin
                $display("ok %0s", cap_name);
            end else begin
                errors_o = errors_o + 1;
            end
            tests_o = tests_o + 1;
            pending = 1'b0;
        end
    end

endmodule

// File: sim/id_stage_properties.sv
`timescale 1ns/1ns

module id_stage_properties
    import id_stage_pkg::*;
(
    input logic    clk_i,
    input logic    rst_i,
    input logic    stall_i,
    input branch_t branch_i,
    input id_ex_t  bundle_i
);

    // a stalled edge must leave a bubble behind
    stall_gives_nop: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> (bundle_i.alu_op == ALU_NOP && !bundle_i.we
                     && bundle_i.op1 == '0 && bundle_i.op2 == '0))
        else $error("stall did not load a bubble");

    reset_clears_we: assert property (@(posedge clk_i) rst_i |=> !bundle_i.we)
        else $error("reset left write enable set");

    target_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        (branch_i.taken && !stall_i) |-> branch_i.target[1:0] == 2'b00)
        else $error("taken branch target not word aligned");

endmodule

bind id_stage id_stage_properties u_props (
    .clk_i(clk), .rst_i(rst), .stall_i(stall_req_o), .branch_i(branch_o),
    .bundle_i(ex_bundle_o)
);

// File: sim/id_stage_tb.sv
`timescale 1ns/1ns

module id_stage_tb
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
();

    localparam int PERIOD = 40;
    localparam int NROWS  = 21;
    localparam int NAME_W = 96;

    logic     clk;
    logic     rst;
    word_t    inst;
    word_t    pc;
    word_t    rf_data1;
    word_t    rf_data2;
    word_t    ex_result;
    fwd_t     mem_fwd;
    rf_read_t rd1;
    rf_read_t rd2;
    branch_t  branch;
    logic     stall_req;
    id_ex_t   ex_bundle;

    // stimulus table
    logic [NAME_W-1:0] t_name[NROWS];
    word_t             t_inst[NROWS];
    word_t             t_pc[NROWS];
    word_t             t_d1[NROWS];
    word_t             t_d2[NROWS];
    word_t             t_exr[NROWS];
    fwd_t              t_mem[NROWS];
    rf_read_t          t_rd1[NROWS];
    rf_read_t          t_rd2[NROWS];
    logic              t_stall[NROWS];
    branch_t           t_br[NROWS];
    id_ex_t            t_bundle[NROWS];
    int                n_rows;

    logic              row_valid;
    logic [NAME_W-1:0] cur_name;
    rf_read_t          cur_rd1;
    rf_read_t          cur_rd2;
    logic              cur_stall;
    branch_t           cur_br;
    id_ex_t            cur_bundle;
    int                tests;
    int                errors;
    integer            seed;
    word_t             a;
    word_t             b;

    id_stage dut (
        .clk(clk), .rst(rst), .inst_i(inst), .pc_i(pc),
        .rf_data1_i(rf_data1), .rf_data2_i(rf_data2), .ex_result_i(ex_result),
        .mem_fwd_i(mem_fwd), .rd1_o(rd1), .rd2_o(rd2), .branch_o(branch),
        .stall_req_o(stall_req), .ex_bundle_o(ex_bundle)
    );

    id_stage_checker #(.NAME_W(NAME_W)) u_checker (
        .clk_i(clk), .row_valid_i(row_valid), .name_i(cur_name),
        .exp_rd1_i(cur_rd1), .exp_rd2_i(cur_rd2),
        .exp_stall_i(cur_stall), .exp_branch_i(cur_br), .exp_bundle_i(cur_bundle),
        .rd1_i(rd1), .rd2_i(rd2),
        .stall_i(stall_req), .branch_i(branch), .bundle_i(ex_bundle),
        .tests_o(tests), .errors_o(errors)
    );

    always #(PERIOD/2) clk = ~clk;

    function automatic word_t rtype_word(int rs, int rt, int rd, int sh, logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic rf_read_t rd_req(int addr);
        return '{en: 1'b1, addr: 5'(addr)};
    endfunction

    function automatic id_ex_t bundle(alu_op_e op, logic s, word_t x, word_t y,
                                      logic we, int wa);
        return '{alu_op: op, is_signed: s, op1: x, op2: y, we: we, waddr: 5'(wa)};
    endfunction

    function automatic fwd_t fwd(logic we, int wa, word_t d);
        return '{we: we, waddr: 5'(wa), data: d};
    endfunction

    task automatic add_row(logic [NAME_W-1:0] name, word_t i, word_t p, word_t d1,
                           word_t d2, word_t exr, fwd_t m, rf_read_t r1, rf_read_t r2,
                           logic st, branch_t br, id_ex_t bd);
        t_name[n_rows]   = name;
        t_inst[n_rows]   = i;
        t_pc[n_rows]     = p;
        t_d1[n_rows]     = d1;
        t_d2[n_rows]     = d2;
        t_exr[n_rows]    = exr;
        t_mem[n_rows]    = m;
        t_rd1[n_rows]    = r1;
        t_rd2[n_rows]    = r2;
        t_stall[n_rows]  = st;
        t_br[n_rows]     = br;
        t_bundle[n_rows] = bd;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        branch_t nb;
        fwd_t    nf;
        word_t   p0;
        nb = '{taken: 1'b0, target: '0};
        nf = fwd(1'b0, 0, '0);
        p0 = 32'h0040_0000;
        // r-type, register data straight through
        a = $random(seed);
        b = $random(seed);
        add_row("add", rtype_word(1, 2, 3, 0, 6'h20), p0, a, b, '0, nf,
                rd_req(1), rd_req(2), 0, nb, bundle(ALU_ADD, 1, a, b, 1, 3));
        a = $random(seed);
        b = $random(seed);
        add_row("subu", rtype_word(4, 6, 7, 0, 6'h23), p0, a, b, '0, nf,
                rd_req(4), rd_req(6), 0, nb, bundle(ALU_SUB, 0, a, b, 1, 7));
        a = $random(seed);
        b = $random(seed);
        add_row("nor", rtype_word(8, 9, 10, 0, 6'h27), p0, a, b, '0, nf,
                rd_req(8), rd_req(9), 0, nb, bundle(ALU_NOR, 0, a, b, 1, 10));
        a = $random(seed);
        b = $random(seed);
        add_row("slt", rtype_word(11, 12, 13, 0, 6'h2a), p0, a, b, '0, nf,
                rd_req(11), rd_req(12), 0, nb, bundle(ALU_SLT, 1, a, b, 1, 13));
        // sllv reads the value from rt on port 1
        a = $random(seed);
        b = $random(seed);
        add_row("sllv", rtype_word(14, 15, 16, 0, 6'h04), p0, a, b, '0, nf,
                rd_req(15), rd_req(14), 0, nb, bundle(ALU_SLL, 0, a, b, 1, 16));
        // immediates
        a = $random(seed);
        add_row("addi", itype_word(6'h08, 17, 18, 16'hfff0), p0, a, '0, '0, nf,
                rd_req(17), '0, 0, nb, bundle(ALU_ADD, 1, a, 32'hffff_fff0, 1, 18));
        a = $random(seed);
        add_row("ori", itype_word(6'h0d, 19, 20, 16'h8001), p0, a, '0, '0, nf,
                rd_req(19), '0, 0, nb, bundle(ALU_OR, 0, a, 32'h0000_8001, 1, 20));
        add_row("lui", itype_word(6'h0f, 0, 21, 16'h1234), p0, '0, '0, '0, nf, '0, '0,
                0, nb, bundle(ALU_MOV, 0, 32'h1234_0000, 32'h1234_0000, 1, 21));
        a = $random(seed);
        add_row("sra", rtype_word(0, 22, 23, 7, 6'h03), p0, a, '0, '0, nf,
                rd_req(22), '0, 0, nb, bundle(ALU_SRA, 0, a, 32'd7, 1, 23));
        // bypass priority, r23 is in EX from the row before
        a = $random(seed);
        b = $random(seed);
        add_row("fwd_ex", rtype_word(23, 24, 25, 0, 6'h20), p0, a, b, 32'he0e0_e0e0,
                fwd(1, 23, 32'h3e3e_3e3e), rd_req(23), rd_req(24), 0, nb,
                bundle(ALU_ADD, 1, 32'he0e0_e0e0, b, 1, 25));
        a = $random(seed);
        b = $random(seed);
        add_row("fwd_mem", rtype_word(26, 27, 28, 0, 6'h20), p0, a, b, 32'he0e0_e0e0,
                fwd(1, 26, 32'h4d4d_4d4d), rd_req(26), rd_req(27), 0, nb,
                bundle(ALU_ADD, 1, 32'h4d4d_4d4d, b, 1, 28));
        a = $random(seed);
        b = $random(seed);
        add_row("fwd_rf", rtype_word(29, 30, 1, 0, 6'h20), p0, a, b, 32'he0e0_e0e0,
                fwd(1, 2, 32'h4d4d_4d4d), rd_req(29), rd_req(30), 0, nb,
                bundle(ALU_ADD, 1, a, b, 1, 1));
        // load followed by a use of its destination
        a = $random(seed);
        add_row("lw", itype_word(6'h23, 2, 5, 16'h0010), p0, a, '0, '0, nf,
                rd_req(2), '0, 0, nb, bundle(ALU_LW, 0, a, 32'h10, 1, 5));
        a = $random(seed);
        b = $random(seed);
        add_row("add_stall", rtype_word(5, 6, 7, 0, 6'h20), p0, a, b, '0, nf,
                rd_req(5), rd_req(6), 1, nb, bundle(ALU_NOP, 0, '0, '0, 0, 0));
        add_row("add_retry", rtype_word(5, 6, 7, 0, 6'h20), p0, a, b, '0,
                fwd(1, 5, 32'h5a5a_5a5a), rd_req(5), rd_req(6), 0, nb,
                bundle(ALU_ADD, 1, 32'h5a5a_5a5a, b, 1, 7));
        // branches and jumps
        a = $random(seed);
        add_row("beq_taken", itype_word(6'h04, 8, 9, 16'h0003), 32'h0040_0100, a, a,
                '0, nf, rd_req(8), rd_req(9), 0,
                '{taken: 1'b1, target: 32'h0040_0110},
                bundle(ALU_NOP, 0, a, a, 0, 0));
        add_row("beq_not", itype_word(6'h04, 8, 9, 16'h0003), 32'h0040_0100, a,
                a ^ 32'h1, '0, nf, rd_req(8), rd_req(9), 0, nb,
                bundle(ALU_NOP, 0, a, a ^ 32'h1, 0, 0));
        add_row("bgtz_neg", itype_word(6'h07, 10, 0, 16'hfffe), 32'h0040_0200,
                32'h8000_0005, '0, '0, nf, rd_req(10), '0, 0, nb,
                bundle(ALU_NOP, 0, 32'h8000_0005, '0, 0, 0));
        add_row("bgtz_pos", itype_word(6'h07, 10, 0, 16'hfffe), 32'h0040_0200, 32'd9,
                '0, '0, nf, rd_req(10), '0, 0,
                '{taken: 1'b1, target: 32'h0040_01fc},
                bundle(ALU_NOP, 0, 32'd9, '0, 0, 0));
        add_row("jal", {6'h03, 26'h010_0040}, 32'h0040_0300, '0, '0, '0, nf, '0, '0, 0,
                '{taken: 1'b1, target: 32'h0040_0100},
                bundle(ALU_BAJ, 0, 32'h0040_0308, 32'h0040_0308, 1, 31));
        add_row("jr", rtype_word(12, 0, 0, 0, 6'h08), 32'h0040_0400, 32'h0040_0abc, '0,
                '0, nf, rd_req(12), '0, 0,
                '{taken: 1'b1, target: 32'h0040_0abc},
                bundle(ALU_NOP, 0, 32'h0040_0abc, '0, 0, 0));
    endtask

    task automatic drive_row(int i);
        inst       = t_inst[i];
        pc         = t_pc[i];
        rf_data1   = t_d1[i];
        rf_data2   = t_d2[i];
        ex_result  = t_exr[i];
        mem_fwd    = t_mem[i];
        cur_name   = t_name[i];
        cur_rd1    = t_rd1[i];
        cur_rd2    = t_rd2[i];
        cur_stall  = t_stall[i];
        cur_br     = t_br[i];
        cur_bundle = t_bundle[i];
        row_valid  = 1'b1;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst       = '0;
        pc         = '0;
        rf_data1   = '0;
        rf_data2   = '0;
        ex_result  = '0;
        mem_fwd    = '0;
        row_valid  = 1'b0;
        cur_name   = '0;
        cur_rd1    = '0;
        cur_rd2    = '0;
        cur_stall  = 1'b0;
        cur_br     = '0;
        cur_bundle = '0;
        n_rows     = 0;
        seed       = 59311;
        build_table();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            if (i > 0) begin
                @(posedge clk);
                #2;
            end
            drive_row(i);
        end
        @(posedge clk);
        #2;
        row_valid = 1'b0;
        wait (tests == n_rows);
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // every row takes one cycle, plus reset and some slack
    initial begin
        #((NROWS + 10) * PERIOD + 2 * PERIOD);
        $display("timeout: the checker did not finish all rows in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module branch_unit
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  word_t        pc_i,
    input  word_t        inst_i,
    input  branch_kind_e kind_i,
    input  word_t        op1_i,
    input  word_t        op2_i,
    output branch_t      branch_o
);

    word_t pc_plus4;
    word_t rel_target;
    word_t jump_target;
    logic  is_eq;
    logic  is_neg;
    logic  is_zero;
    logic  taken;

    assign pc_plus4 = pc_i + `PC_STEP;

    // word offset relative to the delay slot
    assign rel_target = pc_plus4 + {{(`WORD_WIDTH-`IMM_WIDTH-2){inst_i[`IMM_WIDTH-1]}},
                                    inst_i[`IMM_WIDTH-1:0], 2'b00};
    assign jump_target = {pc_plus4[`WORD_WIDTH-1:`J_INDEX_WIDTH+2],
                          inst_i[`J_INDEX_WIDTH-1:0], 2'b00};

    assign is_eq   = (op1_i == op2_i);
    assign is_neg  = op1_i[`WORD_WIDTH-1];
    assign is_zero = (op1_i == '0);

    always_comb begin
        case (kind_i)
            BR_EQ:   taken = is_eq;
            BR_NE:   taken = !is_eq;
            BR_LEZ:  taken = is_neg || is_zero;
            BR_GTZ:  taken = !is_neg && !is_zero;
            BR_LTZ:  taken = is_neg;
            BR_GEZ:  taken = !is_neg;
            BR_JUMP, BR_JREG: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign branch_o.taken  = taken;
    assign branch_o.target = !taken             ? '0 :
                             (kind_i == BR_JUMP) ? jump_target :
                             (kind_i == BR_JREG) ? op1_i : rel_target;

endmodule

// File: verilog/id_ex_register.sv
`timescale 1ns/1ns

module id_ex_register
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    stall_i,
    input  decode_t dec_i,
    input  word_t   op1_i,
    input  word_t   op2_i,
    output id_ex_t  bundle_o
);

    localparam id_ex_t BUBBLE = '{alu_op: ALU_NOP, is_signed: 1'b0, op1: '0, op2: '0,
                                  we: 1'b0, waddr: '0};

    always_ff @(posedge clk) begin
        if (rst || stall_i) begin
            bundle_o <= BUBBLE;
        end else begin
            bundle_o.alu_op    <= dec_i.alu_op;
            bundle_o.is_signed <= dec_i.is_signed;
            bundle_o.op1       <= op1_i;
            bundle_o.op2       <= op2_i;
            bundle_o.we        <= dec_i.we;
            bundle_o.waddr     <= dec_i.waddr;
        end
    end

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/1ns

module id_stage
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    inst_i,
    input  word_t    pc_i,
    input  word_t    rf_data1_i,
    input  word_t    rf_data2_i,
    input  word_t    ex_result_i,
    input  fwd_t     mem_fwd_i,
    output rf_read_t rd1_o,
    output rf_read_t rd2_o,
    output branch_t  branch_o,
    output logic     stall_req_o,
    output id_ex_t   ex_bundle_o
);

    decode_t dec;
    word_t   op1;
    word_t   op2;
    fwd_t    ex_fwd;

    assign rd1_o  = dec.rd1;
    assign rd2_o  = dec.rd2;
    // tag of the instruction now in EX, paired with its result
    assign ex_fwd = '{we: ex_bundle_o.we, waddr: ex_bundle_o.waddr, data: ex_result_i};

    inst_decoder u_decoder (.inst_i(inst_i), .pc_i(pc_i), .dec_o(dec));

    operand_bypass u_bypass1 (
        .rd_req_i(dec.rd1), .rf_data_i(rf_data1_i), .imm_i(dec.imm),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd_i), .operand_o(op1)
    );

    operand_bypass u_bypass2 (
        .rd_req_i(dec.rd2), .rf_data_i(rf_data2_i), .imm_i(dec.imm),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd_i), .operand_o(op2)
    );

    branch_unit u_branch (
        .pc_i(pc_i), .inst_i(inst_i), .kind_i(dec.br_kind),
        .op1_i(op1), .op2_i(op2), .branch_o(branch_o)
    );

    load_use_hazard u_hazard (
        .rd1_i(dec.rd1), .rd2_i(dec.rd2), .ex_bundle_i(ex_bundle_o), .stall_o(stall_req_o)
    );

    id_ex_register u_id_ex (
        .clk(clk), .rst(rst), .stall_i(stall_req_o), .dec_i(dec),
        .op1_i(op1), .op2_i(op2), .bundle_o(ex_bundle_o)
    );

endmodule

// File: verilog/id_stage_pkg.sv
package id_stage_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,  ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MOV, ALU_BAJ,
        ALU_LW,  ALU_LB,  ALU_LH,  ALU_LBU, ALU_LHU,
        ALU_SW,  ALU_SB,  ALU_SH
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ, BR_JUMP, BR_JREG
    } branch_kind_e;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
    } rf_read_t;

    typedef struct packed {
        rf_read_t     rd1;
        rf_read_t     rd2;
        logic         we;
        reg_addr_t    waddr;
        alu_op_e      alu_op;
        logic         is_signed;
        word_t        imm;
        branch_kind_e br_kind;
    } decode_t;

    // result tag and data coming back from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      is_signed;
        word_t     op1;
        word_t     op2;
        logic      we;
        reg_addr_t waddr;
    } id_ex_t;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module inst_decoder
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  word_t   inst_i,
    input  word_t   pc_i,
    output decode_t dec_o
);

    opcode_e                    opcode;
    funct_e                     funct;
    regimm_e                    regimm;
    reg_addr_t                  rs;
    reg_addr_t                  rt;
    reg_addr_t                  rd;
    logic [`REG_ADDR_WIDTH-1:0] shamt;
    word_t                      sext_imm;
    word_t                      zext_imm;
    word_t                      upper_imm;
    word_t                      shamt_imm;
    word_t                      link_imm;

    assign opcode = opcode_e'(inst_i[`OPCODE_LSB +: $bits(opcode_e)]);
    assign funct  = funct_e'(inst_i[$bits(funct_e)-1:0]);
    assign rs     = inst_i[`RS_LSB +: `REG_ADDR_WIDTH];
    assign rt     = inst_i[`RT_LSB +: `REG_ADDR_WIDTH];
    assign rd     = inst_i[`RD_LSB +: `REG_ADDR_WIDTH];
    assign shamt  = inst_i[`SHAMT_LSB +: `REG_ADDR_WIDTH];
    assign regimm = regimm_e'(rt);

    assign sext_imm  = {{(`WORD_WIDTH-`IMM_WIDTH){inst_i[`IMM_WIDTH-1]}},
                        inst_i[`IMM_WIDTH-1:0]};
    assign zext_imm  = {{(`WORD_WIDTH-`IMM_WIDTH){1'b0}}, inst_i[`IMM_WIDTH-1:0]};
    assign upper_imm = {inst_i[`IMM_WIDTH-1:0], {(`WORD_WIDTH-`IMM_WIDTH){1'b0}}};
    assign shamt_imm = {{(`WORD_WIDTH-`REG_ADDR_WIDTH){1'b0}}, shamt};
    // return address skips the delay slot
    assign link_imm  = pc_i + `PC_LINK_STEP;

    function automatic alu_op_e funct_op(funct_e f);
        case (f)
            F_ADD, F_ADDU: return ALU_ADD;
            F_SUB, F_SUBU: return ALU_SUB;
            F_AND:         return ALU_AND;
            F_OR:          return ALU_OR;
            F_XOR:         return ALU_XOR;
            F_NOR:         return ALU_NOR;
            F_SLT, F_SLTU: return ALU_SLT;
            F_SLL, F_SLLV: return ALU_SLL;
            F_SRL, F_SRLV: return ALU_SRL;
            F_SRA, F_SRAV: return ALU_SRA;
            default:       return ALU_NOP;
        endcase
    endfunction

    function automatic alu_op_e opcode_op(opcode_e o);
        case (o)
            OP_ADDI, OP_ADDIU: return ALU_ADD;
            OP_SLTI, OP_SLTIU: return ALU_SLT;
            OP_ANDI:           return ALU_AND;
            OP_ORI:            return ALU_OR;
            OP_XORI:           return ALU_XOR;
            OP_LW:             return ALU_LW;
            OP_LB:             return ALU_LB;
            OP_LH:             return ALU_LH;
            OP_LBU:            return ALU_LBU;
            OP_LHU:            return ALU_LHU;
            OP_SW:             return ALU_SW;
            OP_SB:             return ALU_SB;
            OP_SH:             return ALU_SH;
            default:           return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        // anything not matched below stays a bubble
        dec_o = '0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR,
                    F_SLT, F_SLTU, F_SLLV, F_SRLV, F_SRAV: begin
                        if (shamt == '0) begin
                            // variable shifts take the value from rt
                            dec_o.rd1 = '{1'b1, funct inside {F_SLLV, F_SRLV, F_SRAV} ? rt : rs};
                            dec_o.rd2 = '{1'b1, funct inside {F_SLLV, F_SRLV, F_SRAV} ? rs : rt};
                            dec_o.we = 1'b1;
                            dec_o.waddr = rd;
                            dec_o.alu_op = funct_op(funct);
                            dec_o.is_signed = funct inside {F_ADD, F_SUB, F_SLT};
                        end
                    end
                    F_SLL, F_SRL, F_SRA: begin
                        if (rs == '0) begin
                            dec_o.rd1 = '{1'b1, rt};
                            dec_o.imm = shamt_imm;
                            dec_o.we = 1'b1;
                            dec_o.waddr = rd;
                            dec_o.alu_op = funct_op(funct);
                        end
                    end
                    F_JR: begin
                        if (rt == '0 && rd == '0) begin
                            dec_o.rd1 = '{1'b1, rs};
                            dec_o.br_kind = BR_JREG;
                        end
                    end
                    F_JALR: begin
                        if (rt == '0) begin
                            dec_o.rd1 = '{1'b1, rs};
                            dec_o.we = 1'b1;
                            dec_o.waddr = rd;
                            dec_o.imm = link_imm;
                            dec_o.alu_op = ALU_BAJ;
                            dec_o.br_kind = BR_JREG;
                        end
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                dec_o.rd1 = '{1'b1, rs};
                case (regimm)
                    RT_BLTZ:   dec_o.br_kind = BR_LTZ;
                    RT_BGEZ:   dec_o.br_kind = BR_GEZ;
                    RT_BLTZAL, RT_BGEZAL: begin
                        dec_o.br_kind = (regimm == RT_BLTZAL) ? BR_LTZ : BR_GEZ;
                        dec_o.we = 1'b1;
                        dec_o.waddr = `LINK_REG;
                        dec_o.imm = link_imm;
                        dec_o.alu_op = ALU_BAJ;
                    end
                    default:   dec_o = '0;
                endcase
            end
            OP_J: begin
                dec_o.br_kind = BR_JUMP;
            end
            OP_JAL: begin
                dec_o.br_kind = BR_JUMP;
                dec_o.we = 1'b1;
                dec_o.waddr = `LINK_REG;
                dec_o.imm = link_imm;
                dec_o.alu_op = ALU_BAJ;
            end
            OP_BEQ, OP_BNE: begin
                dec_o.rd1 = '{1'b1, rs};
                dec_o.rd2 = '{1'b1, rt};
                dec_o.br_kind = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
            end
            OP_BLEZ, OP_BGTZ: begin
                if (rt == '0) begin
                    dec_o.rd1 = '{1'b1, rs};
                    dec_o.br_kind = (opcode == OP_BLEZ) ? BR_LEZ : BR_GTZ;
                end
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
            OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU: begin
                dec_o.rd1 = '{1'b1, rs};
                dec_o.we = 1'b1;
                dec_o.waddr = rt;
                dec_o.imm = opcode inside {OP_ANDI, OP_ORI, OP_XORI} ? zext_imm : sext_imm;
                dec_o.alu_op = opcode_op(opcode);
                dec_o.is_signed = opcode inside {OP_ADDI, OP_SLTI};
            end
            OP_LUI: begin
                if (rs == '0) begin
                    dec_o.imm = upper_imm;
                    dec_o.we = 1'b1;
                    dec_o.waddr = rt;
                    dec_o.alu_op = ALU_MOV;
                end
            end
            OP_SW, OP_SB, OP_SH: begin
                dec_o.rd1 = '{1'b1, rs};
                dec_o.rd2 = '{1'b1, rt};
                dec_o.alu_op = opcode_op(opcode);
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/load_use_hazard.sv
`timescale 1ns/1ns

module load_use_hazard
    import id_stage_pkg::*;
(
    input  rf_read_t rd1_i,
    input  rf_read_t rd2_i,
    input  id_ex_t   ex_bundle_i,
    output logic     stall_o
);

    logic ex_is_load;
    logic rd1_hit;
    logic rd2_hit;

    // load data only exists after MEM, so EX cannot forward it
    assign ex_is_load = ex_bundle_i.alu_op inside {ALU_LW, ALU_LB, ALU_LH, ALU_LBU, ALU_LHU};

    assign rd1_hit = rd1_i.en && (rd1_i.addr == ex_bundle_i.waddr);
    assign rd2_hit = rd2_i.en && (rd2_i.addr == ex_bundle_i.waddr);

    assign stall_o = ex_is_load && (rd1_hit || rd2_hit);

endmodule

// File: verilog/mips_isa_pkg.sv
`include "mips_macros.svh"

package mips_isa_pkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00, F_SRL  = 6'h02, F_SRA  = 6'h03,
        F_SLLV = 6'h04, F_SRLV = 6'h06, F_SRAV = 6'h07,
        F_JR   = 6'h08, F_JALR = 6'h09,
        F_ADD  = 6'h20, F_ADDU = 6'h21, F_SUB  = 6'h22, F_SUBU = 6'h23,
        F_AND  = 6'h24, F_OR   = 6'h25, F_XOR  = 6'h26, F_NOR  = 6'h27,
        F_SLT  = 6'h2a, F_SLTU = 6'h2b
    } funct_e;

    // rt field codes under REGIMM
    typedef enum logic [4:0] {
        RT_BLTZ   = 5'h00,
        RT_BGEZ   = 5'h01,
        RT_BLTZAL = 5'h10,
        RT_BGEZAL = 5'h11
    } regimm_e;

endpackage

// File: verilog/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
`define LINK_REG        5'd31
`define PC_STEP         32'd4
`define PC_LINK_STEP    32'd8

// instruction field positions
`define OPCODE_LSB      26
`define RS_LSB          21
`define RT_LSB          16
`define RD_LSB          11
`define SHAMT_LSB       6
`define IMM_WIDTH       16
`define J_INDEX_WIDTH   26

`endif

// File: verilog/operand_bypass.sv
`timescale 1ns/1ns

module operand_bypass
    import mips_isa_pkg::*;
    import id_stage_pkg::*;
(
    input  rf_read_t rd_req_i,
    input  word_t    rf_data_i,
    input  word_t    imm_i,
    input  fwd_t     ex_fwd_i,
    input  fwd_t     mem_fwd_i,
    output word_t    operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.waddr == rd_req_i.addr);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.waddr == rd_req_i.addr);

    // youngest result wins
    always_comb begin
        if (!rd_req_i.en) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.data;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule
